// ==== decode_pkg.sv ====
package decode_pkg;

    // Field widths
    localparam int OPCODE_W = 7;
    localparam int FUNCT3_W = 3;
    localparam int FUNCT7_W = 7;
    localparam int ALU_OP_W = 5;

    // RV32I major opcodes
    localparam logic [OPCODE_W-1:0] OP_LUI     = 7'b0110111;
    localparam logic [OPCODE_W-1:0] OP_AUIPC   = 7'b0010111;
    localparam logic [OPCODE_W-1:0] OP_JAL     = 7'b1101111;
    localparam logic [OPCODE_W-1:0] OP_JALR    = 7'b1100111;
    localparam logic [OPCODE_W-1:0] OP_BRANCH  = 7'b1100011;
    localparam logic [OPCODE_W-1:0] OP_LOAD    = 7'b0000011;
    localparam logic [OPCODE_W-1:0] OP_STORE   = 7'b0100011;
    localparam logic [OPCODE_W-1:0] OP_ALU_IMM = 7'b0010011;
    localparam logic [OPCODE_W-1:0] OP_ALU_REG = 7'b0110011;
    localparam logic [OPCODE_W-1:0] OP_FENCE   = 7'b0001111;
    localparam logic [OPCODE_W-1:0] OP_SYSTEM  = 7'b1110011;

    // ALU funct3, shared by the immediate and register forms
    localparam logic [FUNCT3_W-1:0] F3_ADD_SUB = 3'b000;
    localparam logic [FUNCT3_W-1:0] F3_SLL     = 3'b001;
    localparam logic [FUNCT3_W-1:0] F3_SLT     = 3'b010;
    localparam logic [FUNCT3_W-1:0] F3_SLTU    = 3'b011;
    localparam logic [FUNCT3_W-1:0] F3_XOR     = 3'b100;
    localparam logic [FUNCT3_W-1:0] F3_SRL_SRA = 3'b101;
    localparam logic [FUNCT3_W-1:0] F3_OR      = 3'b110;
    localparam logic [FUNCT3_W-1:0] F3_AND     = 3'b111;

    // Branch funct3
    localparam logic [FUNCT3_W-1:0] F3_BEQ  = 3'b000;
    localparam logic [FUNCT3_W-1:0] F3_BNE  = 3'b001;
    localparam logic [FUNCT3_W-1:0] F3_BLT  = 3'b100;
    localparam logic [FUNCT3_W-1:0] F3_BGE  = 3'b101;
    localparam logic [FUNCT3_W-1:0] F3_BLTU = 3'b110;
    localparam logic [FUNCT3_W-1:0] F3_BGEU = 3'b111;

    // Only two funct7 patterns exist in RV32I
    localparam logic [FUNCT7_W-1:0] F7_BASE = 7'b0000000;
    localparam logic [FUNCT7_W-1:0] F7_ALT  = 7'b0100000;

    typedef enum logic [3:0] {
        CLS_LUI,
        CLS_AUIPC,
        CLS_JAL,
        CLS_JALR,
        CLS_BRANCH,
        CLS_LOAD,
        CLS_STORE,
        CLS_ALU_IMM,
        CLS_ALU_REG,
        CLS_ILLEGAL
    } instr_class_e;

    // What the downstream decoders need from one instruction
    typedef struct packed {
        instr_class_e              instr_class;
        logic [FUNCT3_W-1:0]       funct3;
        logic                      alt;
    } decode_class_t;

    typedef enum logic [1:0] {
        SRC_B_REG     = 2'b00,
        SRC_B_IMM     = 2'b01,
        SRC_B_PC_STEP = 2'b10
    } src_b_e;

    typedef enum logic [2:0] {
        IMM_I     = 3'b000,
        IMM_S     = 3'b001,
        IMM_B     = 3'b010,
        IMM_U     = 3'b011,
        IMM_J     = 3'b100,
        IMM_SHAMT = 3'b101
    } imm_fmt_e;

    typedef enum logic [1:0] {
        RES_ALU     = 2'b00,
        RES_MEM     = 2'b01,
        RES_PC_LINK = 2'b10
    } result_sel_e;

    typedef enum logic [1:0] {
        LEN_BYTE = 2'b00,
        LEN_HALF = 2'b01,
        LEN_WORD = 2'b10
    } mem_len_e;

    typedef enum logic [ALU_OP_W-1:0] {
        ALU_ADD    = 5'd0,
        ALU_SUB    = 5'd1,
        ALU_SLL    = 5'd2,
        ALU_SLT    = 5'd3,
        ALU_SLTU   = 5'd4,
        ALU_XOR    = 5'd5,
        ALU_SRL    = 5'd6,
        ALU_SRA    = 5'd7,
        ALU_OR     = 5'd8,
        ALU_AND    = 5'd9,
        ALU_PASS_B = 5'd10
    } alu_op_e;

endpackage

// ==== instr_classifier.sv ====
module instr_classifier (
    input  logic [decode_pkg::OPCODE_W-1:0] opcode,
    input  logic [decode_pkg::FUNCT3_W-1:0] funct3,
    input  logic [decode_pkg::FUNCT7_W-1:0] funct7,
    output decode_pkg::decode_class_t       cls,
    output logic                            err
);

    decode_pkg::instr_class_e kind;

    always_comb begin
        kind = decode_pkg::CLS_ILLEGAL;
        case (opcode)
            // U and J formats carry no function fields
            decode_pkg::OP_LUI:   kind = decode_pkg::CLS_LUI;
            decode_pkg::OP_AUIPC: kind = decode_pkg::CLS_AUIPC;
            decode_pkg::OP_JAL:   kind = decode_pkg::CLS_JAL;
            decode_pkg::OP_JALR: begin
                if (funct3 == 3'b000) begin
                    kind = decode_pkg::CLS_JALR;
                end
            end
            decode_pkg::OP_BRANCH: begin
                if (funct3 inside {decode_pkg::F3_BEQ, decode_pkg::F3_BNE,
                                   decode_pkg::F3_BLT, decode_pkg::F3_BGE,
                                   decode_pkg::F3_BLTU, decode_pkg::F3_BGEU}) begin
                    kind = decode_pkg::CLS_BRANCH;
                end
            end
            decode_pkg::OP_LOAD: begin
                // LB, LH, LW, LBU, LHU
                if (funct3 inside {3'b000, 3'b001, 3'b010, 3'b100, 3'b101}) begin
                    kind = decode_pkg::CLS_LOAD;
                end
            end
            decode_pkg::OP_STORE: begin
                if (funct3 inside {3'b000, 3'b001, 3'b010}) begin
                    kind = decode_pkg::CLS_STORE;
                end
            end
            decode_pkg::OP_ALU_IMM: begin
                // Shift immediates reuse funct7 as the upper shamt field
                case (funct3)
                    decode_pkg::F3_SLL: begin
                        if (funct7 == decode_pkg::F7_BASE) begin
                            kind = decode_pkg::CLS_ALU_IMM;
                        end
                    end
                    decode_pkg::F3_SRL_SRA: begin
                        if (funct7 == decode_pkg::F7_BASE || funct7 == decode_pkg::F7_ALT) begin
                            kind = decode_pkg::CLS_ALU_IMM;
                        end
                    end
                    default: kind = decode_pkg::CLS_ALU_IMM;
                endcase
            end
            decode_pkg::OP_ALU_REG: begin
                if (funct7 == decode_pkg::F7_BASE) begin
                    kind = decode_pkg::CLS_ALU_REG;
                end else if (funct7 == decode_pkg::F7_ALT &&
                             funct3 inside {decode_pkg::F3_ADD_SUB,
                                            decode_pkg::F3_SRL_SRA}) begin
                    kind = decode_pkg::CLS_ALU_REG;
                end
            end
            // Not supported by this core
            decode_pkg::OP_FENCE, decode_pkg::OP_SYSTEM: kind = decode_pkg::CLS_ILLEGAL;
            default: kind = decode_pkg::CLS_ILLEGAL;
        endcase
    end

    always_comb begin
        cls.instr_class = kind;
        cls.funct3      = funct3;
        cls.alt         = funct7[5];
    end

    assign err = (kind == decode_pkg::CLS_ILLEGAL);

endmodule

// ==== datapath_ctrl.sv ====
module datapath_ctrl (
    input  decode_pkg::decode_class_t cls,
    output logic                      reg_write,
    output logic                      jump,
    output logic                      branch,
    output logic                      pc_jal_src,
    output logic                      jalr_en,
    output logic                      alu_src_sel_a,
    output decode_pkg::src_b_e        alu_src_sel_b,
    output decode_pkg::imm_fmt_e      imm_ctrl,
    output decode_pkg::result_sel_e   result_sel
);

    always_comb begin
        // Inactive values cover illegal instructions too
        reg_write     = 1'b0;
        jump          = 1'b0;
        branch        = 1'b0;
        pc_jal_src    = 1'b0;
        jalr_en       = 1'b0;
        alu_src_sel_a = 1'b0;
        alu_src_sel_b = decode_pkg::SRC_B_REG;
        imm_ctrl      = decode_pkg::IMM_I;
        result_sel    = decode_pkg::RES_ALU;

        case (cls.instr_class)
            decode_pkg::CLS_LUI, decode_pkg::CLS_AUIPC: begin
                // U formats take operand A from the PC
                reg_write     = 1'b1;
                alu_src_sel_a = 1'b1;
                alu_src_sel_b = decode_pkg::SRC_B_IMM;
                imm_ctrl      = decode_pkg::IMM_U;
            end
            decode_pkg::CLS_JAL: begin
                reg_write     = 1'b1;
                jump          = 1'b1;
                pc_jal_src    = 1'b1;
                alu_src_sel_b = decode_pkg::SRC_B_PC_STEP;
                imm_ctrl      = decode_pkg::IMM_J;
                result_sel    = decode_pkg::RES_PC_LINK;
            end
            decode_pkg::CLS_JALR: begin
                // Target comes from rs1 plus offset through the ALU
                reg_write     = 1'b1;
                jump          = 1'b1;
                pc_jal_src    = 1'b1;
                jalr_en       = 1'b1;
                alu_src_sel_b = decode_pkg::SRC_B_IMM;
                imm_ctrl      = decode_pkg::IMM_I;
                result_sel    = decode_pkg::RES_PC_LINK;
            end
            decode_pkg::CLS_BRANCH: begin
                branch        = 1'b1;
                alu_src_sel_b = decode_pkg::SRC_B_REG;
                imm_ctrl      = decode_pkg::IMM_B;
            end
            decode_pkg::CLS_LOAD: begin
                reg_write     = 1'b1;
                alu_src_sel_b = decode_pkg::SRC_B_IMM;
                imm_ctrl      = decode_pkg::IMM_I;
                result_sel    = decode_pkg::RES_MEM;
            end
            decode_pkg::CLS_STORE: begin
                alu_src_sel_b = decode_pkg::SRC_B_IMM;
                imm_ctrl      = decode_pkg::IMM_S;
            end
            decode_pkg::CLS_ALU_IMM: begin
                reg_write     = 1'b1;
                alu_src_sel_b = decode_pkg::SRC_B_IMM;
                if (cls.funct3 inside {decode_pkg::F3_SLL, decode_pkg::F3_SRL_SRA}) begin
                    imm_ctrl = decode_pkg::IMM_SHAMT;
                end else begin
                    imm_ctrl = decode_pkg::IMM_I;
                end
            end
            decode_pkg::CLS_ALU_REG: begin
                reg_write = 1'b1;
            end
            default: begin
            end
        endcase
    end

endmodule

// ==== mem_access_ctrl.sv ====
module mem_access_ctrl (
    input  decode_pkg::decode_class_t cls,
    output logic                      mem_read,
    output logic                      mem_write_en,
    output logic                      mem_sign,
    output decode_pkg::mem_len_e      mem_length
);

    logic is_load;
    logic is_store;

    assign is_load  = (cls.instr_class == decode_pkg::CLS_LOAD);
    assign is_store = (cls.instr_class == decode_pkg::CLS_STORE);

    always_comb begin
        mem_read     = is_load;
        mem_write_en = is_store;

        // funct3[1:0] already encodes byte, half or word
        if (is_load || is_store) begin
            mem_length = decode_pkg::mem_len_e'(cls.funct3[1:0]);
        end else begin
            mem_length = decode_pkg::LEN_BYTE;
        end

        // Only LB and LH sign extend
        // funct3[2] marks the unsigned loads
        mem_sign = is_load && (cls.funct3[2:1] == 2'b00);
    end

endmodule

// ==== alu_op_decoder.sv ====
module alu_op_decoder (
    input  decode_pkg::decode_class_t cls,
    output decode_pkg::alu_op_e       alu_op
);

    logic is_alu;

    assign is_alu = (cls.instr_class == decode_pkg::CLS_ALU_IMM) ||
                    (cls.instr_class == decode_pkg::CLS_ALU_REG);

    always_comb begin
        // Address and link math all use the adder
        alu_op = decode_pkg::ALU_ADD;

        if (cls.instr_class == decode_pkg::CLS_LUI) begin
            alu_op = decode_pkg::ALU_PASS_B;
        end else if (cls.instr_class == decode_pkg::CLS_BRANCH) begin
            case (cls.funct3)
                decode_pkg::F3_BEQ, decode_pkg::F3_BNE:   alu_op = decode_pkg::ALU_SUB;
                decode_pkg::F3_BLT, decode_pkg::F3_BGE:   alu_op = decode_pkg::ALU_SLT;
                decode_pkg::F3_BLTU, decode_pkg::F3_BGEU: alu_op = decode_pkg::ALU_SLTU;
                default:                                  alu_op = decode_pkg::ALU_ADD;
            endcase
        end else if (is_alu) begin
            case (cls.funct3)
                decode_pkg::F3_ADD_SUB: begin
                    // ADDI has no SUB form since its bit 30 is immediate data
                    if (cls.instr_class == decode_pkg::CLS_ALU_REG && cls.alt) begin
                        alu_op = decode_pkg::ALU_SUB;
                    end else begin
                        alu_op = decode_pkg::ALU_ADD;
                    end
                end
                decode_pkg::F3_SLL:  alu_op = decode_pkg::ALU_SLL;
                decode_pkg::F3_SLT:  alu_op = decode_pkg::ALU_SLT;
                decode_pkg::F3_SLTU: alu_op = decode_pkg::ALU_SLTU;
                decode_pkg::F3_XOR:  alu_op = decode_pkg::ALU_XOR;
                decode_pkg::F3_SRL_SRA: begin
                    if (cls.alt) begin
                        alu_op = decode_pkg::ALU_SRA;
                    end else begin
                        alu_op = decode_pkg::ALU_SRL;
                    end
                end
                decode_pkg::F3_OR:   alu_op = decode_pkg::ALU_OR;
                decode_pkg::F3_AND:  alu_op = decode_pkg::ALU_AND;
            endcase
        end
    end

endmodule

// ==== instr_decoder.sv ====
module instr_decoder (
    input  logic [decode_pkg::OPCODE_W-1:0] opcode,
    input  logic [decode_pkg::FUNCT3_W-1:0] funct3,
    input  logic [decode_pkg::FUNCT7_W-1:0] funct7,
    output logic                            reg_write,
    output logic                            mem_write_en,
    output logic                            jump,
    output logic                            branch,
    output logic [1:0]                      result_sel,
    output logic                            pc_jal_src,
    output logic                            alu_src_sel_a,
    output logic [1:0]                      alu_src_sel_b,
    output logic [decode_pkg::ALU_OP_W-1:0] alu_op,
    output logic [2:0]                      imm_ctrl,
    output logic                            mem_read,
    output logic                            mem_sign,
    output logic [1:0]                      mem_length,
    output logic                            jalr_en,
    output logic                            err
);

    // Class, funct3 and alt bit shared by the three control decoders
    decode_pkg::decode_class_t cls;

    instr_classifier u_classifier (
        .opcode (opcode),
        .funct3 (funct3),
        .funct7 (funct7),
        .cls    (cls),
        .err    (err)
    );

    datapath_ctrl u_datapath_ctrl (
        .cls           (cls),
        .reg_write     (reg_write),
        .jump          (jump),
        .branch        (branch),
        .pc_jal_src    (pc_jal_src),
        .jalr_en       (jalr_en),
        .alu_src_sel_a (alu_src_sel_a),
        .alu_src_sel_b (alu_src_sel_b),
        .imm_ctrl      (imm_ctrl),
        .result_sel    (result_sel)
    );

    mem_access_ctrl u_mem_access_ctrl (
        .cls          (cls),
        .mem_read     (mem_read),
        .mem_write_en (mem_write_en),
        .mem_sign     (mem_sign),
        .mem_length   (mem_length)
    );

    alu_op_decoder u_alu_op_decoder (
        .cls    (cls),
        .alu_op (alu_op)
    );

endmodule

// ==== decode_ref_model.svh ====
`ifndef DECODE_REF_MODEL_SVH
`define DECODE_REF_MODEL_SVH

// Expected class straight from the legality rules
function automatic decode_pkg::instr_class_e ref_classify(
    input logic [6:0] op,
    input logic [2:0] f3,
    input logic [6:0] f7
);
    decode_pkg::instr_class_e c;
    c = decode_pkg::CLS_ILLEGAL;
    if (op == decode_pkg::OP_LUI) c = decode_pkg::CLS_LUI;
    else if (op == decode_pkg::OP_AUIPC) c = decode_pkg::CLS_AUIPC;
    else if (op == decode_pkg::OP_JAL) c = decode_pkg::CLS_JAL;
    else if (op == decode_pkg::OP_JALR && f3 == 3'd0) c = decode_pkg::CLS_JALR;
    else if (op == decode_pkg::OP_BRANCH && f3 != 3'd2 && f3 != 3'd3) c = decode_pkg::CLS_BRANCH;
    else if (op == decode_pkg::OP_LOAD && f3 != 3'd3 && f3 < 3'd6) c = decode_pkg::CLS_LOAD;
    else if (op == decode_pkg::OP_STORE && f3 <= 3'd2) c = decode_pkg::CLS_STORE;
    else if (op == decode_pkg::OP_ALU_IMM && (f3 != 3'd1 || f7 == 7'h00) &&
             (f3 != 3'd5 || f7 == 7'h00 || f7 == 7'h20)) c = decode_pkg::CLS_ALU_IMM;
    else if (op == decode_pkg::OP_ALU_REG &&
             (f7 == 7'h00 || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5))))
        c = decode_pkg::CLS_ALU_REG;
    return c;
endfunction

// {reg_write, sel_a, sel_b, imm_ctrl, result_sel, jump, branch, pc_jal_src, jalr_en}
function automatic logic [12:0] ref_datapath(
    input decode_pkg::instr_class_e c,
    input logic [2:0]               f3
);
    logic [12:0] v;
    case (c)
        decode_pkg::CLS_LUI, decode_pkg::CLS_AUIPC:
            v = {1'b1, 1'b1, 2'b01, 3'b011, 2'b00, 4'b0000};
        decode_pkg::CLS_JAL:     v = {1'b1, 1'b0, 2'b10, 3'b100, 2'b10, 4'b1010};
        decode_pkg::CLS_JALR:    v = {1'b1, 1'b0, 2'b01, 3'b000, 2'b10, 4'b1011};
        decode_pkg::CLS_BRANCH:  v = {1'b0, 1'b0, 2'b00, 3'b010, 2'b00, 4'b0100};
        decode_pkg::CLS_LOAD:    v = {1'b1, 1'b0, 2'b01, 3'b000, 2'b01, 4'b0000};
        decode_pkg::CLS_STORE:   v = {1'b0, 1'b0, 2'b01, 3'b001, 2'b00, 4'b0000};
        decode_pkg::CLS_ALU_IMM: begin
            v = {1'b1, 1'b0, 2'b01, 3'b000, 2'b00, 4'b0000};
            if (f3 == 3'd1 || f3 == 3'd5) v[8:6] = 3'b101;
        end
        decode_pkg::CLS_ALU_REG: v = {1'b1, 1'b0, 2'b00, 3'b000, 2'b00, 4'b0000};
        default:                 v = '0;
    endcase
    return v;
endfunction

// {mem_read, mem_write_en, mem_sign, mem_length}
function automatic logic [4:0] ref_mem(input decode_pkg::instr_class_e c, input logic [2:0] f3);
    logic ld;
    logic st;
    ld = (c == decode_pkg::CLS_LOAD);
    st = (c == decode_pkg::CLS_STORE);
    return {ld, st, ld && f3 <= 3'd1, (ld || st) ? f3[1:0] : 2'b00};
endfunction

function automatic logic [4:0] ref_alu_op(
    input decode_pkg::instr_class_e c,
    input logic [2:0]               f3,
    input logic                     alt
);
    logic [4:0] map [8];
    map = '{5'd0, 5'd2, 5'd3, 5'd4, 5'd5, 5'd6, 5'd8, 5'd9};
    if (c == decode_pkg::CLS_LUI) return 5'd10;
    if (c == decode_pkg::CLS_BRANCH) return (f3[2] == 1'b0) ? 5'd1 : (f3[1] ? 5'd4 : 5'd3);
    if (c != decode_pkg::CLS_ALU_IMM && c != decode_pkg::CLS_ALU_REG) return 5'd0;
    if (f3 == 3'd5 && alt) return 5'd7;
    if (f3 == 3'd0 && alt && c == decode_pkg::CLS_ALU_REG) return 5'd1;
    return map[f3];
endfunction

`endif

// ==== instr_decoder_tb.sv ====
module instr_decoder_tb;

    logic       clk;
    logic       rst = 1'b1;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;

    logic       reg_write;
    logic       mem_write_en;
    logic       jump;
    logic       branch;
    logic [1:0] result_sel;
    logic       pc_jal_src;
    logic       alu_src_sel_a;
    logic [1:0] alu_src_sel_b;
    logic [4:0] alu_op;
    logic [2:0] imm_ctrl;
    logic       mem_read;
    logic       mem_sign;
    logic [1:0] mem_length;
    logic       jalr_en;
    logic       err;

    // Opcodes the random stimulus favours
    logic [6:0] known_ops [11];

    `include "decode_ref_model.svh"

    instr_decoder u_dut (
        .opcode        (opcode),
        .funct3        (funct3),
        .funct7        (funct7),
        .reg_write     (reg_write),
        .mem_write_en  (mem_write_en),
        .jump          (jump),
        .branch        (branch),
        .result_sel    (result_sel),
        .pc_jal_src    (pc_jal_src),
        .alu_src_sel_a (alu_src_sel_a),
        .alu_src_sel_b (alu_src_sel_b),
        .alu_op        (alu_op),
        .imm_ctrl      (imm_ctrl),
        .mem_read      (mem_read),
        .mem_sign      (mem_sign),
        .mem_length    (mem_length),
        .jalr_en       (jalr_en),
        .err           (err)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic report_mismatch(input string name, input string field,
                                   input string exp_s, input string act_s);
        $display("MISMATCH %s %s expected %s actual %s", name, field, exp_s, act_s);
        abort_run("decoder output differs from the expected value");
    endtask

    task automatic check_outputs(input string name);
        decode_pkg::instr_class_e c;
        logic        err_exp;
        logic [12:0] dp_exp;
        logic [12:0] dp_act;
        logic [4:0]  mem_exp;
        logic [4:0]  mem_act;
        logic [4:0]  alu_exp;
        c       = ref_classify(opcode, funct3, funct7);
        err_exp = (c == decode_pkg::CLS_ILLEGAL);
        dp_exp  = ref_datapath(c, funct3);
        mem_exp = ref_mem(c, funct3);
        alu_exp = ref_alu_op(c, funct3, funct7[5]);
        // Same bit order as the reference functions
        dp_act  = {reg_write, alu_src_sel_a, alu_src_sel_b, imm_ctrl, result_sel,
                   jump, branch, pc_jal_src, jalr_en};
        mem_act = {mem_read, mem_write_en, mem_sign, mem_length};
        assert (err == err_exp) else
            report_mismatch(name, "err", $sformatf("%b", err_exp), $sformatf("%b", err));
        assert (dp_act == dp_exp) else
            report_mismatch(name, "datapath", $sformatf("%h", dp_exp), $sformatf("%h", dp_act));
        assert (mem_act == mem_exp) else
            report_mismatch(name, "memory", $sformatf("%h", mem_exp), $sformatf("%h", mem_act));
        assert (alu_op == alu_exp) else
            report_mismatch(name, "alu_op", $sformatf("%0d", alu_exp), $sformatf("%0d", alu_op));
    endtask

    task automatic apply_instr(input string name, input logic [6:0] op,
                               input logic [2:0] f3, input logic [6:0] f7);
        @(negedge clk);
        opcode = op;
        funct3 = f3;
        funct7 = f7;
        @(posedge clk);
        check_outputs(name);
    endtask

    // Sweeps all eight funct3 values of one opcode
    task automatic sweep_funct3(input string name, input logic [6:0] op, input logic [6:0] f7);
        for (int f = 0; f < 8; f++) begin
            apply_instr($sformatf("%s f3=%0d f7=%h", name, f, f7), op, f[2:0], f7);
        end
    endtask

    initial begin
        logic [31:0] r;
        logic [6:0]  op;
        logic [6:0]  alu_f7 [3];
        int unsigned waited;
        int          idx;
        opcode = '0;
        funct3 = '0;
        funct7 = '0;
        known_ops = '{decode_pkg::OP_LUI, decode_pkg::OP_AUIPC, decode_pkg::OP_JAL,
                      decode_pkg::OP_JALR, decode_pkg::OP_BRANCH, decode_pkg::OP_LOAD,
                      decode_pkg::OP_STORE, decode_pkg::OP_ALU_IMM, decode_pkg::OP_ALU_REG,
                      decode_pkg::OP_FENCE, decode_pkg::OP_SYSTEM};
        // Base, alternate and one illegal funct7
        alu_f7 = '{decode_pkg::F7_BASE, decode_pkg::F7_ALT, 7'h01};
        void'($urandom(32'hfa9d73ac));

        waited = 0;
        while (rst !== 1'b0) begin
            @(posedge clk);
            waited++;
            if (waited > 10) begin
                abort_run("reset was not released within 10 clock cycles");
            end
        end

        // U and J formats ignore the function fields
        apply_instr("LUI", decode_pkg::OP_LUI, 3'd5, 7'h2a);
        apply_instr("AUIPC", decode_pkg::OP_AUIPC, 3'd3, 7'h7f);
        apply_instr("JAL", decode_pkg::OP_JAL, 3'd0, 7'h00);
        sweep_funct3("JALR", decode_pkg::OP_JALR, 7'h00);
        sweep_funct3("BRANCH", decode_pkg::OP_BRANCH, 7'h00);
        sweep_funct3("LOAD", decode_pkg::OP_LOAD, 7'h00);
        sweep_funct3("STORE", decode_pkg::OP_STORE, 7'h00);
        for (int k = 0; k < 3; k++) begin
            sweep_funct3("ALU_IMM", decode_pkg::OP_ALU_IMM, alu_f7[k]);
            sweep_funct3("ALU_REG", decode_pkg::OP_ALU_REG, alu_f7[k]);
        end
        apply_instr("FENCE", decode_pkg::OP_FENCE, 3'd0, 7'h00);
        apply_instr("ECALL", decode_pkg::OP_SYSTEM, 3'd0, 7'h00);
        apply_instr("EBREAK", decode_pkg::OP_SYSTEM, 3'd0, 7'h00);
        apply_instr("unknown 7f", 7'h7f, 3'd0, 7'h00);
        apply_instr("unknown 00", 7'h00, 3'd2, 7'h20);

        // Three in four draws use a known opcode
        for (int i = 0; i < 2000; i++) begin
            r = $urandom();
            if (r[9:8] != 2'b00) begin
                idx = $urandom_range(10, 0);
                op  = known_ops[idx];
            end else begin
                op = r[6:0];
            end
            apply_instr($sformatf("random %0d", i), op, r[12:10], r[19:13]);
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+.
decode_pkg.sv
instr_classifier.sv
datapath_ctrl.sv
mem_access_ctrl.sv
alu_op_decoder.sv
instr_decoder.sv
instr_decoder_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --assert --top-module instr_decoder_tb -f vlog.f -o sim_instr_decoder

./obj_dir/sim_instr_decoder 2>&1 | tee sim.log

if grep -qF '*** PASSED ***' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
